//--- Makefile
# Verilator simulation of the GPIO bridge.
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module gpio_bridge_tb -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/Vgpio_bridge_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- list.f
logic/gpio_pkg.sv
logic/apb_reg_port.sv
logic/gpio_input_sync.sv
logic/gpio_regs.sv
logic/gpio_bridge_top.sv
verif/gpio_bridge_assert.sv
verif/gpio_bridge_tb.sv

//--- logic/apb_reg_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB-Lite slave port: turns zero-wait transfers
// into register write strobes and read data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module apb_reg_port (
  input  logic                          pclk,
  input  logic                          rst,
  input  logic [31:0]                   paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [gpio_pkg::APB_DW-1:0]   pwdata,
  input  logic [gpio_pkg::APB_DW-1:0]   rd_value,
  output logic                          pready,
  output logic [gpio_pkg::APB_DW-1:0]   prdata,
  output logic [gpio_pkg::REG_IDX_W-1:0] reg_index,
  output logic [gpio_pkg::REG_IDX_W-1:0] rd_index,
  output logic                          wr_strobe,
  output logic [gpio_pkg::APB_DW-1:0]   wr_data
);
  import gpio_pkg::*;

  apb_state_t state;   // Transfer phase.
  logic       setup;   // Setup cycle seen on the bus.

  assign setup  = psel && !penable;             // First cycle of a transfer.
  assign pready = 1'b1;                         // Never stalls.

  // Read index goes straight to the mux so data is ready at the setup edge.
  assign rd_index = paddr[REG_IDX_W+1:2];       // Word address.

  // Strobe only while the master still holds the write.
  assign wr_strobe = (state == APB_W_ENABLE) && psel && penable && pwrite;

  always_ff @(posedge pclk) begin
    if (rst) begin
      state  <= APB_SETUP;                      // Wait for a setup cycle.
      prdata <= '0;                             // Bus idles at zero.
    end else begin
      case (state)
        APB_SETUP: begin
          prdata <= '0;                         // Nothing driven between reads.
          if (setup) begin
            if (pwrite) begin
              state <= APB_W_ENABLE;            // Commit in the access phase.
            end else begin
              state  <= APB_R_ENABLE;
              prdata <= rd_value;               // Value before any write this cycle.
            end
          end
        end
        APB_W_ENABLE: begin
          state  <= APB_SETUP;                  // Zero wait, always one cycle.
          prdata <= '0;
        end
        APB_R_ENABLE: begin
          state  <= APB_SETUP;
          prdata <= '0;                         // Data held only for the access phase.
        end
        default: begin
          state  <= APB_SETUP;                  // Unused encoding.
          prdata <= '0;
        end
      endcase
    end
  end

  // Write target and data captured in setup.
  always_ff @(posedge pclk) begin
    if (setup && pwrite) begin
      reg_index <= paddr[REG_IDX_W+1:2];        // Word address of the write.
      wr_data   <= pwdata;
    end
  end

endmodule

//--- logic/gpio_bridge_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO bridge top: APB-Lite port, pin synchronizer
// and register file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module gpio_bridge_top (
  input  logic                        pclk,
  input  logic                        rst,
  input  logic [31:0]                 paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [gpio_pkg::APB_DW-1:0] pwdata,
  output logic                        pready,
  output logic [gpio_pkg::APB_DW-1:0] prdata,
  input  logic [gpio_pkg::GPIO_W-1:0] gpio_in,
  output logic [gpio_pkg::GPIO_W-1:0] gpio_out,
  output logic [gpio_pkg::GPIO_W-1:0] gpio_oe,
  output logic                        irq
);
  import gpio_pkg::*;

  logic [REG_IDX_W-1:0] reg_index;  // Write target.
  logic [REG_IDX_W-1:0] rd_index;   // Read target, live from paddr.
  logic                 wr_strobe;
  logic [APB_DW-1:0]    wr_data;
  logic [APB_DW-1:0]    rd_value;
  logic [GPIO_W-1:0]    pin_sync;   // Pins after the synchronizer.
  logic [GPIO_W-1:0]    rise_pulse;

  apb_reg_port u_port (
    .pclk, .rst,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .rd_value,
    .pready, .prdata,
    .reg_index, .rd_index, .wr_strobe, .wr_data
  );

  gpio_input_sync u_sync (
    .pclk, .rst,
    .gpio_in,
    .pin_sync, .rise_pulse
  );

  gpio_regs u_regs (
    .pclk, .rst,
    .reg_index, .wr_strobe, .wr_data,
    .rd_index, .pin_sync, .rise_pulse,
    .rd_value,
    .gpio_out, .gpio_oe, .irq
  );

endmodule

//--- logic/gpio_input_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input pin synchronizer with rising-edge pulses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module gpio_input_sync (
  input  logic                        pclk,
  input  logic                        rst,
  input  logic [gpio_pkg::GPIO_W-1:0] gpio_in,
  output logic [gpio_pkg::GPIO_W-1:0] pin_sync,
  output logic [gpio_pkg::GPIO_W-1:0] rise_pulse
);
  import gpio_pkg::*;

  logic [GPIO_W-1:0] meta;     // First stage, may go metastable.
  logic [GPIO_W-1:0] pin_prev; // Synced value one cycle ago.

  always_ff @(posedge pclk) begin
    if (rst) begin
      meta       <= '0;
      pin_sync   <= '0;
      pin_prev   <= '0;                      // Pin high at reset gives one pulse.
      rise_pulse <= '0;
    end else begin
      meta       <= gpio_in;                 // Async pins in.
      pin_sync   <= meta;                    // Stable two edges after a change.
      pin_prev   <= pin_sync;
      rise_pulse <= pin_sync & ~pin_prev;    // One cycle per 0 to 1 step.
    end
  end

  // pin_sync moves at edge two and rise_pulse follows at edge three,
  // so the status register sets at edge four.

endmodule

//--- logic/gpio_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO bridge package: widths, register index map
// and the APB slave state encoding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package gpio_pkg;

  localparam int GPIO_W    = 16; // Pin count, one register word.
  localparam int APB_DW    = 32; // APB data bus width.
  localparam int REG_IDX_W = 3;  // Register index, taken from paddr[4:2].

  // Register map, word addressed.
  localparam logic [REG_IDX_W-1:0] REG_DATA_OUT   = 3'd0; // Read/write.
  localparam logic [REG_IDX_W-1:0] REG_DIRECTION  = 3'd1; // 1 makes the pin an output.
  localparam logic [REG_IDX_W-1:0] REG_DATA_IN    = 3'd2; // Read only.
  localparam logic [REG_IDX_W-1:0] REG_IRQ_ENABLE = 3'd3; // Read/write.
  localparam logic [REG_IDX_W-1:0] REG_IRQ_STATUS = 3'd4; // Write 1 to clear.
  // Indices 5 to 7 read zero and drop writes.

  // Slave FSM: setup, then one enable cycle.
  typedef enum logic [1:0] {
    APB_SETUP    = 2'd0, // Idle or setup phase.
    APB_W_ENABLE = 2'd1, // Access phase of a write.
    APB_R_ENABLE = 2'd2  // Access phase of a read.
  } apb_state_t;

endpackage

//--- logic/gpio_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO register file: data out, direction, edge
// interrupt enable and status, read mux and irq.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module gpio_regs (
  input  logic                           pclk,
  input  logic                           rst,
  input  logic [gpio_pkg::REG_IDX_W-1:0] reg_index,
  input  logic                           wr_strobe,
  input  logic [gpio_pkg::APB_DW-1:0]    wr_data,
  input  logic [gpio_pkg::REG_IDX_W-1:0] rd_index,
  input  logic [gpio_pkg::GPIO_W-1:0]    pin_sync,
  input  logic [gpio_pkg::GPIO_W-1:0]    rise_pulse,
  output logic [gpio_pkg::APB_DW-1:0]    rd_value,
  output logic [gpio_pkg::GPIO_W-1:0]    gpio_out,
  output logic [gpio_pkg::GPIO_W-1:0]    gpio_oe,
  output logic                           irq
);
  import gpio_pkg::*;

  logic [GPIO_W-1:0] data_out;    // Output latch.
  logic [GPIO_W-1:0] direction;   // 1 = output.
  logic [GPIO_W-1:0] irq_enable;  // Interrupt mask.
  logic [GPIO_W-1:0] irq_status;  // Sticky rising edges.
  logic [GPIO_W-1:0] wr_word;     // Bus data, pin wide.
  logic [GPIO_W-1:0] status_clr;  // Bits cleared by a status write.
  logic [GPIO_W-1:0] rd_word;     // Selected register.
  logic              we_data_out;
  logic              we_direction;
  logic              we_irq_enable;
  logic              we_irq_status;

  assign wr_word = wr_data[GPIO_W-1:0]; // Upper bus bits have no register.

  // Write decode. REG_DATA_IN and unmapped indices have no enable.
  assign we_data_out   = wr_strobe && (reg_index == REG_DATA_OUT);
  assign we_direction  = wr_strobe && (reg_index == REG_DIRECTION);
  assign we_irq_enable = wr_strobe && (reg_index == REG_IRQ_ENABLE);
  assign we_irq_status = wr_strobe && (reg_index == REG_IRQ_STATUS);

  assign status_clr = we_irq_status ? wr_word : '0; // Write 1 to clear.

  always_ff @(posedge pclk) begin
    if (rst) begin
      data_out   <= '0;
      direction  <= '0;                 // All pins inputs.
      irq_enable <= '0;
      irq_status <= '0;
    end else begin
      if (we_data_out) begin
        data_out <= wr_word;
      end
      if (we_direction) begin
        direction <= wr_word;
      end
      if (we_irq_enable) begin
        irq_enable <= wr_word;
      end
      // A new edge wins over a clear of the same bit.
      irq_status <= (irq_status & ~status_clr) | rise_pulse;
    end
  end

  // Read mux, unmapped indices give zero.
  always_comb begin
    case (rd_index)
      REG_DATA_OUT:   rd_word = data_out;
      REG_DIRECTION:  rd_word = direction;
      REG_DATA_IN:    rd_word = pin_sync;     // Synchronized pins.
      REG_IRQ_ENABLE: rd_word = irq_enable;
      REG_IRQ_STATUS: rd_word = irq_status;
      default:        rd_word = '0;
    endcase
  end

  assign rd_value = APB_DW'(rd_word);         // Bits above the pins read zero.

  assign gpio_out = data_out;                 // Pins follow the registers.
  assign gpio_oe  = direction;

  // Level interrupt, high while any enabled edge is pending.
  assign irq = |(irq_status & irq_enable);

endmodule

//--- verif/gpio_bridge_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB and pin protocol assertions for the bridge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module gpio_bridge_assert (
  input logic                        pclk,
  input logic                        rst,
  input logic                        psel,
  input logic                        penable,
  input logic                        pwrite,
  input logic                        pready,
  input logic [gpio_pkg::APB_DW-1:0] prdata,
  input logic                        wr_strobe,
  input logic [gpio_pkg::GPIO_W-1:0] gpio_out,
  input logic [gpio_pkg::GPIO_W-1:0] gpio_oe
);

  // Zero wait states, ever.
  a_pready_high: assert property (@(posedge pclk) pready)
    else $error("pready went low");

  // Read data only shows during the access phase of a read.
  a_prdata_idle: assert property (@(posedge pclk) disable iff (rst)
    !(psel && penable && !pwrite) |-> (prdata == '0))
    else $error("prdata nonzero outside a read access phase");

  // Pins move only on the edge after a write strobe.
  a_pins_stable: assert property (@(posedge pclk) disable iff (rst)
    !wr_strobe |=> ($stable(gpio_out) && $stable(gpio_oe)))
    else $error("gpio_out or gpio_oe changed without a write");

endmodule

bind gpio_bridge_top gpio_bridge_assert u_assert (
  .pclk, .rst,
  .psel, .penable, .pwrite,
  .pready, .prdata,
  .wr_strobe,
  .gpio_out, .gpio_oe
);

//--- verif/gpio_bridge_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO bridge testbench: APB driver, register model
// and directed tests for pins and edge interrupts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module gpio_bridge_tb;
  import gpio_pkg::*;

  localparam int TEST_CYCLES = 1500;            // Rough length of all tests.
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES; // Hang guard.
  localparam int SETTLE      = 6;               // Pin to irq takes four edges.

  logic                 pclk;
  logic                 rst;
  logic [31:0]          paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [APB_DW-1:0]    pwdata;
  logic                 pready;
  logic [APB_DW-1:0]    prdata;
  logic [GPIO_W-1:0]    gpio_in;
  logic [GPIO_W-1:0]    gpio_out;
  logic [GPIO_W-1:0]    gpio_oe;
  logic                 irq;

  logic [GPIO_W-1:0]    m_data_out;   // Model of the registers.
  logic [GPIO_W-1:0]    m_direction;
  logic [GPIO_W-1:0]    m_irq_enable;
  logic [GPIO_W-1:0]    m_irq_status;
  logic [GPIO_W-1:0]    m_pins;       // Last value driven on gpio_in.
  logic [31:0]          lfsr;         // Random source.
  int                   cycle_count = 0;

  gpio_bridge_top uut (
    .pclk, .rst,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .pready, .prdata,
    .gpio_in, .gpio_out, .gpio_oe,
    .irq
  );

  initial pclk = 1'b0;
  always #2 pclk = ~pclk;                       // 4 ns period.

  always @(posedge pclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped by the cycle limit.");
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] expected_reg(input logic [REG_IDX_W-1:0] idx);
    case (idx)
      REG_DATA_OUT:   return 32'(m_data_out);
      REG_DIRECTION:  return 32'(m_direction);
      REG_DATA_IN:    return 32'(m_pins);     // Settled pins.
      REG_IRQ_ENABLE: return 32'(m_irq_enable);
      REG_IRQ_STATUS: return 32'(m_irq_status);
      default:        return 32'd0;           // Unmapped.
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_pins();
    check_value("pready", 32'(pready), 32'd1);
    check_value("gpio_out", 32'(gpio_out), 32'(m_data_out));
    check_value("gpio_oe", 32'(gpio_oe), 32'(m_direction));
    check_value("irq", 32'(irq), 32'(|(m_irq_status & m_irq_enable)));
  endtask

  // Tasks start and end 1 ns after a rising edge, so transfers go back to back.
  task automatic apb_write(input logic [REG_IDX_W-1:0] idx, input logic [31:0] data);
    paddr   = {27'd0, idx, 2'b00};              // Setup phase.
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge pclk);
    #1 penable = 1'b1;                          // Access phase.
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [REG_IDX_W-1:0] idx, output logic [31:0] data);
    paddr   = {27'd0, idx, 2'b00};
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge pclk);
    #1 penable = 1'b1;
    data = prdata;                              // Latched at the setup edge.
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [REG_IDX_W-1:0] idx, input logic [31:0] data);
    apb_write(idx, data);
    case (idx)
      REG_DATA_OUT:   m_data_out = data[GPIO_W-1:0];
      REG_DIRECTION:  m_direction = data[GPIO_W-1:0];
      REG_IRQ_ENABLE: m_irq_enable = data[GPIO_W-1:0];
      REG_IRQ_STATUS: m_irq_status = m_irq_status & ~data[GPIO_W-1:0];
      default:        ;                         // Read-only or unmapped.
    endcase
    check_pins();
  endtask

  task automatic read_and_check(input logic [REG_IDX_W-1:0] idx);
    logic [31:0] got;
    apb_read(idx, got);
    check_value($sformatf("prdata idx %0d", idx), got, expected_reg(idx));
  endtask

  task automatic drive_pins(input logic [GPIO_W-1:0] value);
    gpio_in      = value;
    m_irq_status = m_irq_status | (value & ~m_pins); // Rising bits only.
    m_pins       = value;
    repeat (SETTLE) @(posedge pclk);
    #1;
    check_pins();
  endtask

  task automatic test_reset();
    check_pins();
    for (int i = 0; i < 8; i++) begin
      read_and_check(REG_IDX_W'(i));
    end
  endtask

  task automatic test_out_dir();
    repeat (8) begin
      write_reg(REG_DATA_OUT, rand_bits(32));   // Upper bits must drop.
      write_reg(REG_DIRECTION, rand_bits(32));
      read_and_check(REG_DATA_OUT);
      read_and_check(REG_DIRECTION);
    end
    write_reg(REG_DATA_IN, rand_bits(32));
    for (int i = 5; i < 8; i++) begin
      write_reg(REG_IDX_W'(i), 32'hFFFF_FFFF);
    end
    for (int i = 0; i < 8; i++) begin
      read_and_check(REG_IDX_W'(i));
    end
  endtask

  task automatic test_input();
    repeat (20) begin
      drive_pins(GPIO_W'(rand_bits(16)));
      read_and_check(REG_DATA_IN);
    end
  endtask

  task automatic test_edge_irq();
    drive_pins('0);
    write_reg(REG_IRQ_STATUS, 32'hFFFF_FFFF);   // Start clean.
    read_and_check(REG_IRQ_STATUS);
    write_reg(REG_IRQ_ENABLE, 32'h0000_0F0F);
    drive_pins(16'h3000);                       // Masked pins only.
    read_and_check(REG_IRQ_STATUS);
    drive_pins(16'h3104);                       // Two enabled rises.
    read_and_check(REG_IRQ_STATUS);
    write_reg(REG_IRQ_STATUS, 32'h0000_0100);   // irq holds on bit 2.
    read_and_check(REG_IRQ_STATUS);
    write_reg(REG_IRQ_STATUS, 32'h0000_0004);   // Last enabled bit goes.
    read_and_check(REG_IRQ_STATUS);
    write_reg(REG_IRQ_STATUS, 32'h0000_F000);
    read_and_check(REG_IRQ_STATUS);
  endtask

  task automatic test_mixed();
    logic [REG_IDX_W-1:0] idx;
    for (int n = 0; n < 100; n++) begin
      if (rand_bits(3) == 32'd0) begin
        drive_pins(m_pins ^ GPIO_W'(rand_bits(16)));
      end
      idx = REG_IDX_W'(rand_bits(3));
      if (rand_bits(1) == 32'd1) begin
        write_reg(idx, rand_bits(32));
      end else begin
        read_and_check(idx);
      end
    end
  endtask

  initial begin
    rst          = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    gpio_in      = '0;
    m_data_out   = '0;
    m_direction  = '0;
    m_irq_enable = '0;
    m_irq_status = '0;
    m_pins       = '0;
    lfsr         = 32'd73242;                   // Fixed seed.
    repeat (5) @(posedge pclk);
    #1 rst = 1'b0;
    test_reset();
    test_out_dir();
    test_input();
    test_edge_irq();
    test_mixed();
    $display("TEST PASSED");
    $finish;
  end

endmodule
